// File: prg_loader_top.f
+incdir+src
+incdir+tests
src/prg_loader_pkg.sv
src/reset_sequencer.sv
src/prg_stream_parser.sv
src/basic_ptr_injector.sv
src/mem_slot_writer.sv
src/autotype_keys.sv
src/prg_loader_top.sv
tests/tb_prg_loader.sv

// File: Makefile
# Verilator build and run of the PRG loader testbench

VERILATOR         ?= verilator
TOP               ?= tb_prg_loader
FILELIST          ?= prg_loader_top.f
BUILD_DIR         ?= obj_dir
LOG               ?= sim.log
COLD_RESET_CYCLES ?= 50
KEY_STEP_CYCLES   ?= 20
VFLAGS            ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-GCOLD_RESET_CYCLES=$(COLD_RESET_CYCLES) \
		-GKEY_STEP_CYCLES=$(KEY_STEP_CYCLES) \
		--Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/prg_golden.txt
// Word 0: number of records. Each record: load address, payload count,
// payload bytes one per word, expected end address (load address + count)
0003
// Start of a BASIC line at the BASIC start
0801 0005 000b 0008 000a 0000 009e 0806
// Machine code at C000
c000 0003 00a9 0000 0060 c003
// Payload that crosses a page boundary
10fe 0006 0011 0022 0033 0044 0055 0066 1104

// File: tests/tb_checks.svh
/*
 * Testbench checks: compare tasks for memory writes, key events and the
 * computer reset, error counters, per-test report and closing summary
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_cnt       = 0;
int check_cnt     = 0;
int test_cnt      = 0;
int test_fail_cnt = 0;
int test_err_base = 0;

task automatic check_write(input mem_addr_t got_addr, input mem_data_t got_data,
		input mem_addr_t exp_addr, input mem_data_t exp_data);
	check_cnt++;
	if (got_addr !== exp_addr) begin
		err_cnt++;
		$display("FAILED mem_addr_o: got %h, expected %h", got_addr, exp_addr);
	end
	if (got_data !== exp_data) begin
		err_cnt++;
		$display("FAILED mem_data_o at %h: got %h, expected %h",
			got_addr, got_data, exp_data);
	end
endtask

task automatic check_key(input ps2_key_t exp_key);
	check_cnt++;
	if (key_o !== exp_key) begin
		err_cnt++;
		$display("FAILED key_o: got %h, expected %h", key_o, exp_key);
	end
endtask

task automatic check_reset(input logic exp_level);
	check_cnt++;
	if (c64_reset_n_o !== exp_level) begin
		err_cnt++;
		$display("FAILED c64_reset_n_o: got %h, expected %h", c64_reset_n_o, exp_level);
	end
endtask

// Timing and protocol problems that have no single expected value
task automatic note_failure(input string what);
	err_cnt++;
	$display("%s", what);
endtask

task automatic finish_test(input string name);
	test_cnt++;
	if (err_cnt == test_err_base) begin
		$display("test %0d, %s: ok", test_cnt, name);
	end else begin
		test_fail_cnt++;
		$display("test %0d, %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
	end
	test_err_base = err_cnt;
endtask

task automatic print_summary();
	$display("%0d tests, %0d failed, %0d checks, %0d errors",
		test_cnt, test_fail_cnt, check_cnt, err_cnt);
endtask

`endif

// File: tests/tb_prg_loader.sv
/*
 * PRG loader testbench with clock and reset, golden record reader, host
 * download driver, memory slot generator, write monitor and timeout
 */
`timescale 1ns/100ps
`default_nettype none

module tb_prg_loader #(
	parameter int COLD_RESET_CYCLES = 50,
	parameter int KEY_STEP_CYCLES   = 20
);
	import prg_loader_pkg::*;

	localparam mem_addr_t   KERNAL_READY      = 16'hFFCF;
	localparam mem_addr_t   BASIC_START       = 16'h0801;
	localparam mem_addr_t   KERNAL_BUSY       = 16'hE5CD;
	localparam stream_idx_t PRG_INDEX         = 8'd4;
	localparam int          LOAD_RESET_CYCLES = 255;
	localparam int          SLOT_MAX          = 9;
	localparam int          ADDR_DELAY_MAX    = 16;
	localparam logic [7:0]  RUN_CODES [4]     = '{8'h2D, 8'h3C, 8'h31, 8'h5A};

	logic        clk_sys     = 1'b0;
	logic        reset_n     = 1'b0;
	logic        reset_req_i = 1'b0;
	logic        dl_active_i = 1'b0;
	stream_idx_t dl_index_i  = '0;
	logic        dl_wr_i     = 1'b0;
	logic [24:0] dl_addr_i   = '0;
	mem_data_t   dl_data_i   = '0;
	logic        io_cycle_i  = 1'b0;
	mem_addr_t   c64_addr_i  = KERNAL_BUSY;
	ps2_key_t    host_key_i  = '0;
	logic        c64_reset_n_o;
	logic        dl_wait_o;
	logic        mem_we_o;
	mem_addr_t   mem_addr_o;
	mem_data_t   mem_data_o;
	ps2_key_t    key_o;

	logic [15:0] golden [0:255];
	mem_addr_t   seen_addr_q [$];
	mem_data_t   seen_data_q [$];
	logic        we_prev       = 1'b0;
	logic [1:0]  io_hist       = 2'b00;
	int          cycle_cnt     = 0;
	int          timeout_limit = 1000000;

	`include "tb_checks.svh"

	prg_loader_top #(
		.COLD_RESET_CYCLES(COLD_RESET_CYCLES),
		.KEY_STEP_CYCLES  (KEY_STEP_CYCLES)
	) prg_loader_top_i (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.reset_req_i  (reset_req_i),
		.dl_active_i  (dl_active_i),
		.dl_index_i   (dl_index_i),
		.dl_wr_i      (dl_wr_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.io_cycle_i   (io_cycle_i),
		.c64_addr_i   (c64_addr_i),
		.host_key_i   (host_key_i),
		.c64_reset_n_o(c64_reset_n_o),
		.dl_wait_o    (dl_wait_o),
		.mem_we_o     (mem_we_o),
		.mem_addr_o   (mem_addr_o),
		.mem_data_o   (mem_data_o),
		.key_o        (key_o)
	);

	always #2 clk_sys = ~clk_sys;

	// ============================================================
	// Computer model of memory slot and KERNAL address
	// ============================================================
	initial begin : slot_gen
		int slot_left;
		int addr_delay;
		void'($urandom(32'h8ca3));
		slot_left  = 1;
		addr_delay = 0;
		forever begin
			@(negedge clk_sys);
			// Slot high for 2 to 5 cycles and low for 1 to 4
			if (slot_left <= 1) begin
				io_cycle_i = ~io_cycle_i;
				slot_left  = io_cycle_i ? 2 + int'($urandom % 4) : 1 + int'($urandom % 4);
			end else begin
				slot_left--;
			end
			if (c64_reset_n_o === 1'b0) begin
				c64_addr_i = KERNAL_BUSY;
				addr_delay = 1 + int'($urandom % ADDR_DELAY_MAX);
			end else if (addr_delay > 0) begin
				addr_delay--;
				if (addr_delay == 0) begin
					c64_addr_i = KERNAL_READY;
				end
			end
		end
	end

	// Slot level at the last two rising edges, as the DUT sees it
	always @(posedge clk_sys) begin
		io_hist <= {io_hist[0], io_cycle_i};
	end

	// Each rising edge of mem_we_o is one write
	always @(negedge clk_sys) begin
		if (mem_we_o === 1'b1 && we_prev !== 1'b1) begin
			seen_addr_q.push_back(mem_addr_o);
			seen_data_q.push_back(mem_data_o);
			if (io_hist !== 2'b10) begin
				note_failure("mem_we_o rose outside the first cycle after the slot fell");
			end
		end
		if (mem_we_o === 1'b0 && we_prev === 1'b1 && io_hist !== 2'b11) begin
			note_failure("mem_we_o fell before the second high cycle of the slot");
		end
		we_prev = mem_we_o;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > timeout_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
			$display("sim failed");
			$finish;
		end
	end

	// ============================================================
	// Host side tasks
	// ============================================================
	task automatic send_byte(input logic [24:0] offset, input mem_data_t data);
		while (dl_wait_o !== 1'b0) @(negedge clk_sys);
		dl_addr_i = offset;
		dl_data_i = data;
		dl_wr_i   = 1'b1;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		// dl_wait_o answers two cycles after the strobe
		@(negedge clk_sys);
	endtask

	task automatic expect_write(input mem_addr_t exp_addr, input mem_data_t exp_data);
		while (seen_addr_q.size() == 0) @(negedge clk_sys);
		check_write(seen_addr_q.pop_front(), seen_data_q.pop_front(), exp_addr, exp_data);
	endtask

	task automatic expect_keys();
		ps2_key_t prev_key;
		logic     strobe;
		logic     pressed;
		int       gap;
		strobe = host_key_i[10];
		for (int ev = 0; ev < 8; ev++) begin
			prev_key = key_o;
			gap      = 0;
			while (key_o === prev_key) begin
				@(negedge clk_sys);
				gap++;
			end
			strobe  = ~strobe;
			pressed = (ev % 2 == 0);
			check_key({strobe, pressed, 1'b0, RUN_CODES[ev / 2]});
			if (ev > 0 && gap != KEY_STEP_CYCLES) begin
				note_failure($sformatf("key event %0d came %0d cycles after the one before",
					ev, gap));
			end
		end
	endtask

	task automatic cold_boot();
		int low_cycles;
		check_reset(1'b0);
		low_cycles = 0;
		while (c64_reset_n_o !== 1'b1) begin
			low_cycles++;
			@(negedge clk_sys);
		end
		if (low_cycles < COLD_RESET_CYCLES) begin
			note_failure($sformatf("cold reset lasted only %0d cycles", low_cycles));
		end
		while (c64_addr_i !== KERNAL_READY) @(negedge clk_sys);
		repeat (4) @(negedge clk_sys);
		if (seen_addr_q.size() != 0) begin
			note_failure("mem_we_o pulsed before any download");
		end
		if (dl_wait_o !== 1'b0) begin
			note_failure("dl_wait_o is high with no download");
		end
		finish_test("cold reset");
	endtask

	task automatic run_record(input int pos);
		mem_addr_t load_addr;
		mem_addr_t end_exp;
		int        n_bytes;
		int        low_cycles;
		load_addr = golden[pos];
		n_bytes   = int'(golden[pos + 1]);
		end_exp   = golden[pos + 2 + n_bytes];

		// Opening a PRG download resets the computer and holds the host
		dl_index_i  = PRG_INDEX;
		dl_active_i = 1'b1;
		while (dl_wait_o !== 1'b1) @(negedge clk_sys);
		check_reset(1'b0);
		low_cycles = 0;
		while (dl_wait_o === 1'b1) begin
			if (c64_reset_n_o === 1'b0) begin
				low_cycles++;
			end
			@(negedge clk_sys);
		end
		check_reset(1'b1);
		if (c64_addr_i !== KERNAL_READY) begin
			note_failure("dl_wait_o fell before the KERNAL ready address");
		end
		if (low_cycles < LOAD_RESET_CYCLES) begin
			note_failure($sformatf("load reset lasted only %0d cycles", low_cycles));
		end

		send_byte(25'd0, load_addr[7:0]);
		send_byte(25'd1, load_addr[15:8]);
		for (int i = 0; i < n_bytes; i++) begin
			send_byte(25'(i + 2), golden[pos + 2 + i][7:0]);
		end
		while (dl_wait_o !== 1'b0) @(negedge clk_sys);
		dl_active_i = 1'b0;

		for (int i = 0; i < n_bytes; i++) begin
			expect_write(load_addr + 16'(i), golden[pos + 2 + i][7:0]);
		end
		// BASIC pointers in zero page order
		expect_write(16'h002B, BASIC_START[7:0]);
		expect_write(16'h002C, BASIC_START[15:8]);
		for (int p = 0; p < 3; p++) begin
			expect_write(16'h002D + 16'(2 * p), end_exp[7:0]);
			expect_write(16'h002E + 16'(2 * p), end_exp[15:8]);
		end
		expect_write(16'h00AC, 8'h00);
		expect_write(16'h00AD, 8'h00);
		expect_write(16'h00AE, end_exp[7:0]);
		expect_write(16'h00AF, end_exp[15:8]);

		expect_keys();
		// Host owns the key stream again and sends a new key with a toggled strobe
		host_key_i = {~host_key_i[10], 1'b1, 1'b0, 8'h1C};
		repeat (2) @(negedge clk_sys);
		check_key(host_key_i);
		if (seen_addr_q.size() != 0) begin
			note_failure("extra memory writes after the BASIC pointers");
		end
		finish_test($sformatf("load %h, %0d bytes", load_addr, n_bytes));
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin : main_seq
		int n_tests;
		int pos;
		int total_bytes;
		$readmemh("tests/prg_golden.txt", golden);
		n_tests     = int'(golden[0]);
		pos         = 1;
		total_bytes = 0;
		for (int t = 0; t < n_tests; t++) begin
			total_bytes += int'(golden[pos + 1]);
			pos += int'(golden[pos + 1]) + 3;
		end
		// Payload and zero page scan in slot periods plus resets and keys
		timeout_limit = COLD_RESET_CYCLES + 1000
			+ (total_bytes + 256 * n_tests) * 3 * SLOT_MAX
			+ n_tests * (LOAD_RESET_CYCLES + ADDR_DELAY_MAX + 10 * KEY_STEP_CYCLES);

		repeat (3) @(negedge clk_sys);
		reset_n = 1'b1;
		cold_boot();
		pos = 1;
		for (int t = 0; t < n_tests; t++) begin
			run_record(pos);
			pos += int'(golden[pos + 1]) + 3;
		end

		print_summary();
		if (err_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src/prg_loader_top.sv
/*
 * PRG loader top level: reset sequencer, stream parser, BASIC pointer
 * injector, memory slot writer and keyboard autotyper
 */
`timescale 1ns/100ps
`default_nettype none
`include "prg_loader_params.svh"

module prg_loader_top #(
	parameter int COLD_RESET_CYCLES = `PRG_COLD_RESET_CYCLES,
	parameter int KEY_STEP_CYCLES   = `PRG_KEY_STEP_CYCLES
) (
	input  logic                        clk_sys,
	input  logic                        reset_n,
	input  logic                        reset_req_i,
	input  logic                        dl_active_i,
	input  prg_loader_pkg::stream_idx_t dl_index_i,
	input  logic                        dl_wr_i,
	input  logic [24:0]                 dl_addr_i,
	input  prg_loader_pkg::mem_data_t   dl_data_i,
	input  logic                        io_cycle_i,
	input  prg_loader_pkg::mem_addr_t   c64_addr_i,
	input  prg_loader_pkg::ps2_key_t    host_key_i,
	output logic                        c64_reset_n_o,
	output logic                        dl_wait_o,
	output logic                        mem_we_o,
	output prg_loader_pkg::mem_addr_t   mem_addr_o,
	output prg_loader_pkg::mem_data_t   mem_data_o,
	output prg_loader_pkg::ps2_key_t    key_o
);
	import prg_loader_pkg::*;

	logic      prg_active;
	logic      prg_done;
	mem_addr_t end_addr;
	logic      byte_req;
	mem_addr_t byte_addr;
	mem_data_t byte_data;
	logic      ptr_req;
	mem_addr_t ptr_addr;
	mem_data_t ptr_data;
	logic      inject_busy;
	logic      inject_done;
	logic      slot_busy;
	logic      reset_wait;

	// Host holds off while a write is pending or the computer is not ready
	assign dl_wait_o = slot_busy | reset_wait;

	reset_sequencer #(
		.COLD_CYCLES(COLD_RESET_CYCLES)
	) reset_sequencer_i (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.reset_req_i  (reset_req_i),
		.prg_active_i (prg_active),
		.inject_busy_i(inject_busy),
		.c64_addr_i   (c64_addr_i),
		.c64_reset_n_o(c64_reset_n_o),
		.reset_wait_o (reset_wait)
	);

	prg_stream_parser prg_stream_parser_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.prg_active_o(prg_active),
		.prg_done_o  (prg_done),
		.end_addr_o  (end_addr),
		.byte_req_o  (byte_req),
		.byte_addr_o (byte_addr),
		.byte_data_o (byte_data)
	);

	basic_ptr_injector basic_ptr_injector_i (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.prg_done_i   (prg_done),
		.end_addr_i   (end_addr),
		.slot_busy_i  (slot_busy),
		.ptr_req_o    (ptr_req),
		.ptr_addr_o   (ptr_addr),
		.ptr_data_o   (ptr_data),
		.inject_busy_o(inject_busy),
		.inject_done_o(inject_done)
	);

	mem_slot_writer mem_slot_writer_i (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.byte_req_i (byte_req),
		.byte_addr_i(byte_addr),
		.byte_data_i(byte_data),
		.ptr_req_i  (ptr_req),
		.ptr_addr_i (ptr_addr),
		.ptr_data_i (ptr_data),
		.io_cycle_i (io_cycle_i),
		.slot_busy_o(slot_busy),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	autotype_keys #(
		.STEP_CYCLES(KEY_STEP_CYCLES)
	) autotype_keys_i (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.inject_done_i(inject_done),
		.host_key_i   (host_key_i),
		.key_o        (key_o)
	);

endmodule

`default_nettype wire

// File: src/autotype_keys.sv
/*
 * Keyboard autotyper: after the pointer injection it types RUN and RETURN
 * into the key stream, then hands the stream back to the host
 */
`timescale 1ns/100ps
`default_nettype none
`include "prg_loader_params.svh"

module autotype_keys #(
	parameter int STEP_CYCLES = `PRG_KEY_STEP_CYCLES
) (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  logic                     inject_done_i,
	input  prg_loader_pkg::ps2_key_t host_key_i,
	output prg_loader_pkg::ps2_key_t key_o
);
	import prg_loader_pkg::*;

	// PS/2 set 2 scan codes
	localparam logic [7:0] KEY_R   = 8'h2D;
	localparam logic [7:0] KEY_U   = 8'h3C;
	localparam logic [7:0] KEY_N   = 8'h31;
	localparam logic [7:0] KEY_RET = 8'h5A;

	localparam int TIMER_W = $clog2(STEP_CYCLES + 1);

	key_state_t         state;
	logic [TIMER_W-1:0] step_timer;
	logic [2:0]         step_cnt;
	logic [7:0]         step_code;

	// Two events per key, press then release
	always_comb begin
		case (step_cnt[2:1])
			2'd0:    step_code = KEY_R;
			2'd1:    step_code = KEY_U;
			2'd2:    step_code = KEY_N;
			default: step_code = KEY_RET;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state      <= IDLE;
			step_timer <= '0;
			step_cnt   <= '0;
			key_o      <= '0;
		end else begin
			case (state)
				IDLE: begin
					key_o <= host_key_i;
					if (inject_done_i) begin
						state      <= WAIT;
						step_timer <= '0;
						step_cnt   <= '0;
					end
				end
				WAIT: begin
					// Key stream frozen between events
					step_timer <= step_timer + 1'b1;
					if (step_timer == TIMER_W'(STEP_CYCLES - 2)) begin
						state <= STEP;
					end
				end
				STEP: begin
					// Strobe toggles from the last value seen by the computer
					key_o      <= {~key_o[10], ~step_cnt[0], 1'b0, step_code};
					step_timer <= '0;
					step_cnt   <= step_cnt + 3'd1;
					state      <= (step_cnt == 3'd7) ? IDLE : WAIT;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/mem_slot_writer.sv
/*
 * One-entry memory write buffer: holds a parser or injector request and
 * issues it as a single write pulse in the free memory slot
 */
`timescale 1ns/100ps
`default_nettype none

module mem_slot_writer (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      byte_req_i,
	input  prg_loader_pkg::mem_addr_t byte_addr_i,
	input  prg_loader_pkg::mem_data_t byte_data_i,
	input  logic                      ptr_req_i,
	input  prg_loader_pkg::mem_addr_t ptr_addr_i,
	input  prg_loader_pkg::mem_data_t ptr_data_i,
	input  logic                      io_cycle_i,
	output logic                      slot_busy_o,
	output logic                      mem_we_o,
	output prg_loader_pkg::mem_addr_t mem_addr_o,
	output prg_loader_pkg::mem_data_t mem_data_o
);
	import prg_loader_pkg::*;

	logic      io_cycle_d;
	logic      slot_open;
	logic      slot_close;
	mem_addr_t buf_addr;
	mem_data_t buf_data;

	// Write starts right after the slot falls and ends on its second high cycle
	assign slot_open  = io_cycle_d && !io_cycle_i;
	assign slot_close = io_cycle_d && io_cycle_i;

	assign mem_addr_o = buf_addr;
	assign mem_data_o = buf_data;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d  <= 1'b0;
			slot_busy_o <= 1'b0;
			mem_we_o    <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			if (byte_req_i || ptr_req_i) begin
				slot_busy_o <= 1'b1;
			end
			if (slot_busy_o && !mem_we_o && slot_open) begin
				mem_we_o <= 1'b1;
			end
			if (mem_we_o && slot_close) begin
				mem_we_o    <= 1'b0;
				slot_busy_o <= 1'b0;
			end
		end
	end

	// Request payload, sources never overlap
	always_ff @(posedge clk_sys) begin
		if (byte_req_i) begin
			buf_addr <= byte_addr_i;
			buf_data <= byte_data_i;
		end else if (ptr_req_i) begin
			buf_addr <= ptr_addr_i;
			buf_data <= ptr_data_i;
		end
	end

	req_when_free: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(byte_req_i || ptr_req_i) |-> !slot_busy_o);

endmodule

`default_nettype wire

// File: src/basic_ptr_injector.sv
/*
 * BASIC pointer injector: walks zero page after a PRG load and requests
 * the pointer writes that a BASIC LOAD would have made
 */
`timescale 1ns/100ps
`default_nettype none
`include "prg_loader_params.svh"

module basic_ptr_injector (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      prg_done_i,
	input  prg_loader_pkg::mem_addr_t end_addr_i,
	input  logic                      slot_busy_i,
	output logic                      ptr_req_o,
	output prg_loader_pkg::mem_addr_t ptr_addr_o,
	output prg_loader_pkg::mem_data_t ptr_data_o,
	output logic                      inject_busy_o,
	output logic                      inject_done_o
);
	import prg_loader_pkg::*;

	localparam mem_addr_t BASIC_START = `PRG_BASIC_START;

	logic [8:0] zp_addr;
	mem_addr_t  inj_end;
	logic       zp_hit;
	mem_data_t  zp_data;
	logic       can_step;

	// One request at a time, and only once the writer is free
	assign can_step = inject_busy_o && !slot_busy_i && !ptr_req_o;

	// Pointer map of zero page
	always_comb begin
		zp_hit  = 1'b1;
		zp_data = 8'h00;
		case (zp_addr[7:0])
			// TXTTAB keeps its power-on value
			8'h2B: zp_data = BASIC_START[7:0];
			8'h2C: zp_data = BASIC_START[15:8];
			// Save start cleared as after reset
			8'hAC, 8'hAD: zp_data = 8'h00;
			// VARTAB, ARYTAB, STREND and load end all point past the program
			8'h2D, 8'h2F, 8'h31, 8'hAE: zp_data = inj_end[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: zp_data = inj_end[15:8];
			default: zp_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			inject_busy_o <= 1'b0;
			inject_done_o <= 1'b0;
			ptr_req_o     <= 1'b0;
			zp_addr       <= '0;
		end else begin
			inject_done_o <= 1'b0;
			ptr_req_o     <= 1'b0;
			if (prg_done_i) begin
				inject_busy_o <= 1'b1;
				zp_addr       <= '0;
			end else if (can_step) begin
				if (zp_addr == `PRG_ZP_END) begin
					inject_busy_o <= 1'b0;
					inject_done_o <= 1'b1;
				end else begin
					ptr_req_o <= zp_hit;
					zp_addr   <= zp_addr + 9'd1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (prg_done_i) begin
			inj_end <= end_addr_i;
		end
		if (can_step) begin
			ptr_addr_o <= {8'h00, zp_addr[7:0]};
			ptr_data_o <= zp_data;
		end
	end

	ptr_req_slot_free: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ptr_req_o |-> !slot_busy_i);

endmodule

`default_nettype wire

// File: src/prg_stream_parser.sv
/*
 * PRG stream parser: takes the load address from the two header bytes
 * and turns each payload byte into a memory write request
 */
`timescale 1ns/100ps
`default_nettype none
`include "prg_loader_params.svh"

module prg_stream_parser (
	input  logic                        clk_sys,
	input  logic                        reset_n,
	input  logic                        dl_active_i,
	input  prg_loader_pkg::stream_idx_t dl_index_i,
	input  logic                        dl_wr_i,
	input  logic [24:0]                 dl_addr_i,
	input  prg_loader_pkg::mem_data_t   dl_data_i,
	output logic                        prg_active_o,
	output logic                        prg_done_o,
	output prg_loader_pkg::mem_addr_t   end_addr_o,
	output logic                        byte_req_o,
	output prg_loader_pkg::mem_addr_t   byte_addr_o,
	output prg_loader_pkg::mem_data_t   byte_data_o
);
	import prg_loader_pkg::*;

	logic      is_prg;
	logic      prg_dl;
	logic      prg_wr;
	logic      hdr_byte;
	mem_addr_t wr_addr;

	assign is_prg   = (dl_index_i == `PRG_STREAM_INDEX);
	assign prg_dl   = dl_active_i && is_prg;
	assign prg_wr   = dl_wr_i && prg_dl;
	// Offsets 0 and 1 carry the load address, little endian
	assign hdr_byte = (dl_addr_i == 25'd0) || (dl_addr_i == 25'd1);

	// Next write address, which is also load address plus payload count
	assign end_addr_o = wr_addr;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			prg_active_o <= 1'b0;
			prg_done_o   <= 1'b0;
			byte_req_o   <= 1'b0;
		end else begin
			prg_active_o <= prg_dl;
			prg_done_o   <= prg_active_o && !prg_dl;
			byte_req_o   <= prg_wr && !hdr_byte;
		end
	end

	// ============================================================
	// Address counter and request payload
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (prg_wr) begin
			if (dl_addr_i == 25'd0) begin
				wr_addr[7:0] <= dl_data_i;
			end else if (dl_addr_i == 25'd1) begin
				wr_addr[15:8] <= dl_data_i;
			end else begin
				byte_addr_o <= wr_addr;
				byte_data_o <= dl_data_i;
				wr_addr     <= wr_addr + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/reset_sequencer.sv
/*
 * Computer reset sequencer: cold reset counter, short reset at the start
 * of a PRG download and the wait for the KERNAL ready address
 */
`timescale 1ns/100ps
`default_nettype none
`include "prg_loader_params.svh"

module reset_sequencer #(
	parameter int COLD_CYCLES = `PRG_COLD_RESET_CYCLES,
	parameter int LOAD_CYCLES = `PRG_LOAD_RESET_CYCLES
) (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      reset_req_i,
	input  logic                      prg_active_i,
	input  logic                      inject_busy_i,
	input  prg_loader_pkg::mem_addr_t c64_addr_i,
	output logic                      c64_reset_n_o,
	output logic                      reset_wait_o
);

	localparam int MAX_CYCLES = (COLD_CYCLES > LOAD_CYCLES) ? COLD_CYCLES : LOAD_CYCLES;
	localparam int CNT_W = $clog2(MAX_CYCLES + 1);

	logic [CNT_W-1:0] reset_cnt;
	logic             prg_active_d;
	logic             prg_start;

	assign prg_start = prg_active_i && !prg_active_d;

	always_ff @(posedge clk_sys) begin
		if (!reset_n || reset_req_i) begin
			prg_active_d  <= 1'b0;
			reset_cnt     <= CNT_W'(COLD_CYCLES);
			c64_reset_n_o <= 1'b0;
			reset_wait_o  <= 1'b0;
		end else begin
			prg_active_d <= prg_active_i;
			if (prg_start) begin
				// New PRG: short reset, then hold the host until BASIC is up
				reset_wait_o  <= 1'b1;
				reset_cnt     <= CNT_W'(LOAD_CYCLES);
				c64_reset_n_o <= 1'b0;
			end else if ((prg_active_i || inject_busy_i) && !reset_wait_o) begin
				// Counter frozen while memory is being filled
				reset_cnt <= reset_cnt;
			end else if (reset_cnt == '0) begin
				c64_reset_n_o <= 1'b1;
				if (reset_wait_o && c64_reset_n_o && c64_addr_i == `PRG_KERNAL_READY_ADDR) begin
					reset_wait_o <= 1'b0;
				end
			end else begin
				reset_cnt <= reset_cnt - 1'b1;
			end
		end
	end

	// The wait only ever starts together with a fresh reset
	reset_wait_in_reset: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(reset_wait_o) |-> !c64_reset_n_o);

endmodule

`default_nettype wire

// File: src/prg_loader_pkg.sv
/*
 * Shared types of the PRG loader: memory address and data, PS/2 key
 * event, host stream index and the key injector state encoding
 */
`default_nettype none

package prg_loader_pkg;

	// Computer memory bus
	typedef logic [15:0] mem_addr_t;
	typedef logic [7:0]  mem_data_t;

	// PS/2 key event
	// [7:0] scan code, [8] extended, [9] pressed, [10] toggles per event
	typedef logic [10:0] ps2_key_t;

	// Host download stream index
	typedef logic [7:0] stream_idx_t;

	// Key injector FSM
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		WAIT = 2'd1,
		STEP = 2'd2
	} key_state_t;

endpackage

`default_nettype wire

// File: src/prg_loader_params.svh
/*
 * Reset lengths, key step interval, KERNAL and BASIC addresses and the
 * host stream index of the PRG loader
 */
`ifndef PRG_LOADER_PARAMS_SVH
`define PRG_LOADER_PARAMS_SVH

// ============================================================
// Reset lengths in clk_sys cycles
// ============================================================
`define PRG_COLD_RESET_CYCLES 100000
`define PRG_LOAD_RESET_CYCLES 255

// ============================================================
// Keyboard injection
// ============================================================
// Cycles between two injected key events
`define PRG_KEY_STEP_CYCLES 1280000

// ============================================================
// Addresses and stream
// ============================================================
// KERNAL waits for input here once BASIC is up
`define PRG_KERNAL_READY_ADDR 16'hFFCF
`define PRG_STREAM_INDEX 8'd4
// Zero page scan stops here
`define PRG_ZP_END 9'h100
`define PRG_BASIC_START 16'h0801

`endif
